// ==== Makefile ====
# Verilator build and run of the uncached fetch path testbench

VERILATOR  ?= verilator
TOP        := tb_icache_bypass
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/bypass_order_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// Order FIFO of one-hot port masks, one entry per issued request
// Memory must answer in request order; pushes while full are lost
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bypass_order_fifo
  import icache_bypass_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  logic       push_i,
  input  port_mask_t push_mask_i,
  output logic       full_o,

  input  logic       mem_rsp_valid_i,
  output logic       mem_rsp_ready_o,
  output port_mask_t rsp_strobe_o
);

  port_mask_t             mask_q [ORDER_DEPTH];
  logic [ORDER_PTR_W-1:0] wr_ptr_q;
  logic [ORDER_PTR_W-1:0] rd_ptr_q;
  logic [ORDER_CNT_W-1:0] count_q;
  logic                   pop;

  assign full_o          = (count_q == ORDER_CNT_W'(ORDER_DEPTH));
  assign mem_rsp_ready_o = (count_q != '0);
  assign pop             = mem_rsp_valid_i & mem_rsp_ready_o;

  // The oldest entry names the port that owns this response
  assign rsp_strobe_o = pop ? mask_q[rd_ptr_q] : '0;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mask_q[wr_ptr_q] <= push_mask_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (int'(wr_ptr_q) == ORDER_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == ORDER_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the fill level unchanged
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== design/bypass_port_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Per-port uncached fetch controller, one request in flight
// The requester must hold address and valid until inst_ready_o
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bypass_port_ctrl
  import icache_bypass_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,

  input  logic        inst_valid_i,
  input  fetch_addr_t inst_addr_i,

  input  logic        grant_i,
  input  logic        fifo_full_i,
  input  logic        rsp_strobe_i,
  input  mem_rsp_t    mem_rsp_i,

  output logic        req_valid_o,
  output mem_req_t    req_o,

  output fetch_word_t inst_data_o,
  output logic        inst_error_o,
  output logic        inst_ready_o
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RSP,
    PRESENT
  } state_e;

  state_e                state_d;
  state_e                state_q;
  logic [WORD_SEL_W-1:0] word_sel;

  // Memory only sees line-aligned addresses
  assign req_o.addr = {inst_addr_i[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

  // Word index inside the returned line
  assign word_sel = inst_addr_i[LINE_ALIGN-1:FETCH_ALIGN];

  always_comb begin
    state_d      = state_q;
    req_valid_o  = 1'b0;
    inst_ready_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (inst_valid_i) begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        // Hold back while the order FIFO has no slot for our response
        if (!fifo_full_i) begin
          req_valid_o = 1'b1;
          if (grant_i) begin
            state_d = WAIT_RSP;
          end
        end
      end
      WAIT_RSP: begin
        if (rsp_strobe_i) begin
          state_d = PRESENT;
        end
      end
      PRESENT: begin
        // Registered word is shown for exactly one cycle
        inst_ready_o = 1'b1;
        state_d      = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the addressed word on the edge that accepts the response
  always_ff @(posedge clk_i) begin
    if (rsp_strobe_i) begin
      inst_data_o  <= mem_rsp_i.data[word_sel*FETCH_DW +: FETCH_DW];
      inst_error_o <= mem_rsp_i.error;
    end
  end

endmodule

// ==== design/bypass_rr_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// Combinational round-robin arbiter onto the memory request stream
// Requesters must keep valid high until granted
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bypass_rr_arbiter
  import icache_bypass_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          arst_n_i,

  input  port_mask_t                    req_valid_i,
  input  mem_req_t [NR_FETCH_PORTS-1:0] req_i,
  output port_mask_t                    grant_o,

  output mem_req_t                      mem_req_o,
  output logic                          mem_req_valid_o,
  input  logic                          mem_req_ready_i,

  output logic                          issue_o,
  output port_mask_t                    issue_mask_o
);

  logic [PORT_IDX_W-1:0] rr_q;
  logic [PORT_IDX_W-1:0] rr_idx;
  logic [PORT_IDX_W-1:0] sel_idx;
  logic [PORT_IDX_W-1:0] lock_idx_q;
  logic                  lock_q;

  // Search from the priority pointer upwards, wrapping at the last port
  always_comb begin
    int unsigned cand;
    logic        found;
    rr_idx = rr_q;
    found  = 1'b0;
    for (int unsigned k = 0; k < NR_FETCH_PORTS; k++) begin
      cand = int'(rr_q) + k;
      if (cand >= NR_FETCH_PORTS) begin
        cand = cand - NR_FETCH_PORTS;
      end
      if (!found && req_valid_i[cand]) begin
        rr_idx = PORT_IDX_W'(cand);
        found  = 1'b1;
      end
    end
  end

  // A stalled request keeps its slot so the payload cannot change
  assign sel_idx = lock_q ? lock_idx_q : rr_idx;

  assign mem_req_valid_o = req_valid_i[sel_idx];
  assign mem_req_o       = req_i[sel_idx];
  assign issue_o         = mem_req_valid_o & mem_req_ready_i;

  always_comb begin
    issue_mask_o          = '0;
    issue_mask_o[sel_idx] = 1'b1;
  end

  assign grant_o = issue_o ? issue_mask_o : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= mem_req_valid_o & ~mem_req_ready_i;
      lock_idx_q <= sel_idx;
      // Winner drops to lowest priority after it issues
      if (issue_o) begin
        if (int'(sel_idx) == NR_FETCH_PORTS - 1) begin
          rr_q <= '0;
        end else begin
          rr_q <= sel_idx + 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/icache_bypass_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths and payload types of the uncached fetch path
// Line and word widths must be powers of two, and a line holds
// at least two words
//////////////////////////////////////////////////////////////////////

package icache_bypass_pkg;

  // Fetch side geometry
  localparam int unsigned NR_FETCH_PORTS = 2;
  localparam int unsigned FETCH_AW       = 32;
  localparam int unsigned FETCH_DW       = 32;

  // Line geometry on the memory side
  localparam int unsigned LINE_WIDTH  = 128;
  localparam int unsigned LINE_ALIGN  = 4;
  localparam int unsigned FETCH_ALIGN = 2;
  localparam int unsigned WORD_SEL_W  = LINE_ALIGN - FETCH_ALIGN;

  // Outstanding memory requests tracked by the order FIFO
  localparam int unsigned ORDER_DEPTH = 4;
  localparam int unsigned ORDER_PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int unsigned ORDER_CNT_W = $clog2(ORDER_DEPTH + 1);

  // Binary index of a fetch port
  localparam int unsigned PORT_IDX_W = (NR_FETCH_PORTS > 1) ? $clog2(NR_FETCH_PORTS) : 1;

  typedef logic [FETCH_AW-1:0]       fetch_addr_t;
  typedef logic [FETCH_DW-1:0]       fetch_word_t;
  typedef logic [LINE_WIDTH-1:0]     line_t;
  typedef logic [NR_FETCH_PORTS-1:0] port_mask_t;

  // Line request, the address always has its low LINE_ALIGN bits cleared
  typedef struct packed {
    fetch_addr_t addr;
  } mem_req_t;

  // Line response as returned by memory
  typedef struct packed {
    line_t data;
    logic  error;
  } mem_rsp_t;

endpackage

// ==== design/icache_bypass_top.sv ====
//////////////////////////////////////////////////////////////////////
// Uncached fetch path with NR_FETCH_PORTS fetch ports sharing one
// line-wide memory port; responses must return in request order
// Up to ORDER_DEPTH requests may be outstanding at the memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module icache_bypass_top
  import icache_bypass_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  input  port_mask_t                       inst_valid_i,
  input  fetch_addr_t [NR_FETCH_PORTS-1:0] inst_addr_i,
  output fetch_word_t [NR_FETCH_PORTS-1:0] inst_data_o,
  output port_mask_t                       inst_error_o,
  output port_mask_t                       inst_ready_o,

  output mem_req_t                         mem_req_o,
  output logic                             mem_req_valid_o,
  input  logic                             mem_req_ready_i,

  input  mem_rsp_t                         mem_rsp_i,
  input  logic                             mem_rsp_valid_i,
  output logic                             mem_rsp_ready_o
);

  port_mask_t                    req_valid;
  mem_req_t [NR_FETCH_PORTS-1:0] req;
  port_mask_t                    grant;
  logic                          issue;
  port_mask_t                    issue_mask;
  logic                          fifo_full;
  port_mask_t                    rsp_strobe;

  // One controller per fetch port, all of them see the same response line
  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_port
    bypass_port_ctrl port_ctrl_inst (
      .clk_i        ( clk_i           ),
      .arst_n_i     ( arst_n_i        ),
      .inst_valid_i ( inst_valid_i[i] ),
      .inst_addr_i  ( inst_addr_i[i]  ),
      .grant_i      ( grant[i]        ),
      .fifo_full_i  ( fifo_full       ),
      .rsp_strobe_i ( rsp_strobe[i]   ),
      .mem_rsp_i    ( mem_rsp_i       ),
      .req_valid_o  ( req_valid[i]    ),
      .req_o        ( req[i]          ),
      .inst_data_o  ( inst_data_o[i]  ),
      .inst_error_o ( inst_error_o[i] ),
      .inst_ready_o ( inst_ready_o[i] )
    );
  end

  bypass_rr_arbiter rr_arbiter_inst (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .req_valid_i     ( req_valid       ),
    .req_i           ( req             ),
    .grant_o         ( grant           ),
    .mem_req_o       ( mem_req_o       ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .issue_o         ( issue           ),
    .issue_mask_o    ( issue_mask      )
  );

  // Every issued request leaves its winner mask here until the line returns
  bypass_order_fifo order_fifo_inst (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .push_i          ( issue           ),
    .push_mask_i     ( issue_mask      ),
    .full_o          ( fifo_full       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_ready_o ( mem_rsp_ready_o ),
    .rsp_strobe_o    ( rsp_strobe      )
  );

endmodule

// ==== flist.f ====
design/icache_bypass_pkg.sv
design/bypass_port_ctrl.sv
design/bypass_rr_arbiter.sv
design/bypass_order_fifo.sv
design/icache_bypass_top.sv
verif/tb_clk_gen.sv
verif/tb_icache_bypass.sv

// ==== verif/tb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset, 8 ns period, reset low for 2 cycles
// Reset drops shortly after time zero and is released on a falling edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 4;
  localparam int RESET_CYCLES   = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b1;
    #1;
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== verif/tb_icache_bypass.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench of the uncached fetch path with an in-order line memory
// Port p only fetches lines whose address bit LINE_ALIGN equals p,
// so each response can be traced back to its port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_icache_bypass
  import icache_bypass_pkg::*;
();

  localparam int unsigned NR_FETCHES     = 48;
  localparam int unsigned FETCH_TIMEOUT  = 200;
  localparam int unsigned RUN_TIMEOUT    = 20000;
  localparam int unsigned RESET_TIMEOUT  = 20;
  localparam int unsigned WORDS_PER_LINE = LINE_WIDTH / FETCH_DW;
  localparam fetch_word_t WORD_XOR       = 32'hA5A5_0000;

  logic                             clk;
  logic                             arst_n;
  port_mask_t                       inst_valid    = '0;
  fetch_addr_t [NR_FETCH_PORTS-1:0] inst_addr     = '0;
  fetch_word_t [NR_FETCH_PORTS-1:0] inst_data;
  port_mask_t                       inst_error;
  port_mask_t                       inst_ready;
  mem_req_t                         mem_req;
  logic                             mem_req_valid;
  logic                             mem_req_ready = 1'b0;
  mem_rsp_t                         mem_rsp       = '0;
  logic                             mem_rsp_valid = 1'b0;
  logic                             mem_rsp_ready;

  logic [31:0]  lfsr = 32'h76bd;
  fetch_addr_t  line_q [$];
  logic         presenting  = 1'b0;
  logic         delay_armed = 1'b0;
  logic [2:0]   rsp_delay   = '0;
  int unsigned  started_cnt [NR_FETCH_PORTS] = '{default: 0};
  int unsigned  done_cnt    [NR_FETCH_PORTS] = '{default: 0};
  fetch_word_t  exp_word    [NR_FETCH_PORTS];
  logic         exp_err     [NR_FETCH_PORTS];
  int unsigned  busy_cycles [NR_FETCH_PORTS] = '{default: 0};
  int unsigned  issued_cnt   = 0;
  int unsigned  accepted_cnt = 0;
  int unsigned  since_rst    = 0;
  port_mask_t   hs_mask_q    = '0;
  logic         stall_q      = 1'b0;
  mem_req_t     held_req     = '0;
  int unsigned  mismatch_cnt = 0;
  int unsigned  hang_cnt     = 0;
  int unsigned  timeout_cnt  = 0;

  tb_clk_gen clk_gen_inst (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  icache_bypass_top icache_bypass_top_inst (
    .clk_i           ( clk           ),
    .arst_n_i        ( arst_n        ),
    .inst_valid_i    ( inst_valid    ),
    .inst_addr_i     ( inst_addr     ),
    .inst_data_o     ( inst_data     ),
    .inst_error_o    ( inst_error    ),
    .inst_ready_o    ( inst_ready    ),
    .mem_req_o       ( mem_req       ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_req_ready_i ( mem_req_ready ),
    .mem_rsp_i       ( mem_rsp       ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_ready_o ( mem_rsp_ready )
  );

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Word k of line A is (A + 4k) ^ WORD_XOR, error is bit 31 of A
  function automatic mem_rsp_t build_rsp(input fetch_addr_t line_addr);
    mem_rsp_t rsp;
    for (int k = 0; k < WORDS_PER_LINE; k++) begin
      rsp.data[k*FETCH_DW +: FETCH_DW] = (line_addr + fetch_addr_t'(4 * k)) ^ WORD_XOR;
    end
    rsp.error = line_addr[FETCH_AW-1];
    return rsp;
  endfunction

  function automatic fetch_word_t expected_word(input fetch_addr_t fetch_addr);
    fetch_addr_t line_addr;
    fetch_addr_t offset;
    line_addr = {fetch_addr[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
    offset    = fetch_addr_t'(fetch_addr[LINE_ALIGN-1:FETCH_ALIGN]) << FETCH_ALIGN;
    return (line_addr + offset) ^ WORD_XOR;
  endfunction

  function automatic logic fetches_complete();
    for (int p = 0; p < NR_FETCH_PORTS; p++) begin
      if (done_cnt[p] < NR_FETCHES) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic flag_mismatch(input string msg);
    mismatch_cnt++;
    $display("FAILED at time %0t: %s", $time, msg);
  endtask

  // Memory model and fetch requesters
  always @(posedge clk) begin : drive_ports_and_memory
    logic [31:0] rnd;
    fetch_addr_t addr;
    if (!arst_n) begin
      inst_valid    <= '0;
      mem_req_ready <= 1'b0;
      mem_rsp_valid <= 1'b0;
      presenting  = 1'b0;
      delay_armed = 1'b0;
    end else begin
      if (mem_req_valid && mem_req_ready) begin
        line_q.push_back(mem_req.addr);
      end
      take_bits(1, rnd);
      mem_req_ready <= rnd[0];
      if (mem_rsp_valid && mem_rsp_ready) begin
        line_q.delete(0);
        presenting = 1'b0;
        mem_rsp_valid <= 1'b0;
      end
      // The oldest line goes out after a pause of 0 to 7 cycles
      if (!presenting && line_q.size() != 0) begin
        if (!delay_armed) begin
          take_bits(3, rnd);
          rsp_delay   = rnd[2:0];
          delay_armed = 1'b1;
        end
        if (rsp_delay == 3'd0) begin
          mem_rsp       <= build_rsp(line_q[0]);
          mem_rsp_valid <= 1'b1;
          presenting  = 1'b1;
          delay_armed = 1'b0;
        end else begin
          rsp_delay = rsp_delay - 3'd1;
        end
      end
      for (int p = 0; p < NR_FETCH_PORTS; p++) begin
        if (inst_ready[p]) begin
          done_cnt[p]++;
        end
        if (!inst_valid[p] || inst_ready[p]) begin
          if (started_cnt[p] < NR_FETCHES) begin
            take_bits(FETCH_AW, rnd);
            addr = rnd;
            addr[LINE_ALIGN +: PORT_IDX_W]     = PORT_IDX_W'(p);
            // Walk through every word index of a line
            addr[LINE_ALIGN-1:FETCH_ALIGN]     = WORD_SEL_W'(started_cnt[p]);
            addr[FETCH_ALIGN-1:0]              = '0;
            inst_valid[p] <= 1'b1;
            inst_addr[p]  <= addr;
            exp_word[p]   <= expected_word(addr);
            exp_err[p]    <= addr[FETCH_AW-1];
            started_cnt[p]++;
          end else begin
            inst_valid[p] <= 1'b0;
          end
        end
      end
    end
  end

  always @(posedge clk) begin : check_outputs
    fetch_addr_t rsp_line;
    port_mask_t  hs_mask;
    if (!arst_n) begin
      assert ((inst_ready == '0) && !mem_req_valid && !mem_rsp_ready)
        else flag_mismatch("handshake outputs not low during reset");
      since_rst    = 0;
      issued_cnt   = 0;
      accepted_cnt = 0;
      stall_q      = 1'b0;
      hs_mask_q    = '0;
    end else begin
      if (since_rst == 0) begin
        assert ((inst_ready == '0) && !mem_req_valid && !mem_rsp_ready)
          else flag_mismatch("handshake outputs not low in the cycle after reset");
        since_rst = 1;
      end
      // A port completes exactly one cycle after its response handshake
      assert (inst_ready == hs_mask_q)
        else flag_mismatch($sformatf("inst_ready %b, expected %b", inst_ready, hs_mask_q));
      for (int p = 0; p < NR_FETCH_PORTS; p++) begin
        if (inst_ready[p]) begin
          assert (inst_data[p] == exp_word[p])
            else flag_mismatch($sformatf("port %0d data %h, expected %h",
                                         p, inst_data[p], exp_word[p]));
          assert (inst_error[p] == exp_err[p])
            else flag_mismatch($sformatf("port %0d error %b, expected %b",
                                         p, inst_error[p], exp_err[p]));
        end
        if (inst_valid[p] && !inst_ready[p]) begin
          busy_cycles[p]++;
          if (busy_cycles[p] == FETCH_TIMEOUT) begin
            $display("Port %0d fetch did not complete within %0d cycles", p, FETCH_TIMEOUT);
            hang_cnt++;
          end
        end else begin
          busy_cycles[p] = 0;
        end
      end
      if (mem_req_valid) begin
        assert (mem_req.addr[LINE_ALIGN-1:0] == '0)
          else flag_mismatch($sformatf("request address %h not line aligned", mem_req.addr));
      end
      if (stall_q) begin
        assert (mem_req_valid && (mem_req == held_req))
          else flag_mismatch("stalled memory request dropped or changed");
      end
      stall_q  = mem_req_valid && !mem_req_ready;
      held_req = mem_req;
      hs_mask  = '0;
      if (mem_req_valid && mem_req_ready) begin
        issued_cnt++;
      end
      if (mem_rsp_valid && mem_rsp_ready) begin
        accepted_cnt++;
        rsp_line = mem_rsp.data[FETCH_DW-1:0] ^ WORD_XOR;
        hs_mask[rsp_line[LINE_ALIGN +: PORT_IDX_W]] = 1'b1;
      end
      hs_mask_q = hs_mask;
      assert (issued_cnt - accepted_cnt <= ORDER_DEPTH)
        else flag_mismatch($sformatf("%0d requests outstanding", issued_cnt - accepted_cnt));
    end
  end

  initial begin : run_test
    int unsigned waited;
    waited = 0;
    while (arst_n !== 1'b0 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (arst_n !== 1'b1) begin
      $display("Reset sequence did not complete within %0d cycles", RESET_TIMEOUT);
      timeout_cnt++;
    end else begin
      waited = 0;
      while (!fetches_complete() && waited < RUN_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (!fetches_complete()) begin
        $display("Fetches did not complete within %0d cycles", RUN_TIMEOUT);
        timeout_cnt++;
      end
      repeat (4) @(negedge clk);
    end
    $display("Summary: %0d value errors, %0d stalled fetches, %0d timeouts",
             mismatch_cnt, hang_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && hang_cnt == 0 && timeout_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
